/* hw/fifo_cfg_pkg.sv */
// fifo configuration package
// word width, RAM depth and the vector types that carry them
// shared by the pointer counter, the RAM, the output stage and the top

package fifo_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int data_w    = 32;           // stored word width
  localparam int addr_w    = 4;            // RAM address bits
  localparam int ram_depth = 1 << addr_w;  // RAM words, power of two

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  // one payload word as written and as read
  typedef logic [data_w-1:0] data_t;

  // RAM address, wraps at ram_depth
  typedef logic [addr_w-1:0] addr_t;

  // stored-word count, one extra bit so a full RAM fits
  typedef logic [addr_w:0] level_t;

endpackage

/* hw/fifo_state_pkg.sv */
// prefetch state package
// occupancy of the output stage, counting held words plus RAM reads in flight

package fifo_state_pkg;

  // words owned by the output side, never more than two
  typedef enum logic [1:0] {
    pf_none = 2'd0,  // nothing held, nothing in flight
    pf_one  = 2'd1,  // one word held or in flight
    pf_two  = 2'd2   // output side full, prefetch stalls
  } pf_state_t;

  // state after rd_rst
  localparam pf_state_t pf_reset_state = pf_none;

endpackage

/* hw/fifo_ptr_ctrl.sv */
// fifo pointer control
// write and read RAM pointers plus a stored-word level counter
// full and empty come from registered compares of the next level
// the only place where writes are qualified against full

module fifo_ptr_ctrl
  import fifo_cfg_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst,
  input  logic  wr_en,      // write request from outside
  input  logic  ram_rd_en,  // RAM read issued by prefetch
  output logic  wr_vld,     // RAM not full
  output logic  wr_ok,      // qualified write strobe
  output addr_t wr_addr,
  output addr_t rd_addr,
  output logic  empty       // RAM holds no word
);

  level_t level;      // words in RAM
  level_t level_nxt;  // level after this edge
  logic   full_q;     // registered full flag
  logic   empty_q;    // registered empty flag

  ////////////////////////////////////////////////////////////
  // write qualification
  ////////////////////////////////////////////////////////////

  assign wr_ok  = wr_en & wr_vld;  // drop writes while full
  assign wr_vld = ~full_q;
  assign empty  = empty_q;

  ////////////////////////////////////////////////////////////
  // level counter
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({wr_ok, ram_rd_en})
      2'b10:   level_nxt = level + level_t'(1);  // store only
      2'b01:   level_nxt = level - level_t'(1);  // read only
      default: level_nxt = level;                // both or neither
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      level   <= '0;
      full_q  <= 1'b0;   // wr_vld high out of reset
      empty_q <= 1'b1;
    end
    else
    begin
      level   <= level_nxt;
      full_q  <= (level_nxt == level_t'(ram_depth));  // flag follows strobe by one
      empty_q <= (level_nxt == '0);
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wr_addr <= '0;
      rd_addr <= '0;
    end
    else
    begin
      if (wr_ok)
        wr_addr <= wr_addr + addr_t'(1);  // natural wrap at depth
      if (ram_rd_en)
        rd_addr <= rd_addr + addr_t'(1);
    end
  end

endmodule

/* hw/fifo_sdpram.sv */
// simple dual-port RAM
// synchronous write port, read port with one cycle latency
// read register only loads under ram_rd_en so data holds between reads

module fifo_sdpram
  import fifo_cfg_pkg::*;
(
  input  logic  rd_clk,
  input  logic  wr_ok,      // qualified write
  input  addr_t wr_addr,
  input  data_t wr_data,
  input  logic  ram_rd_en,  // read enable, also clock enable of ram_dat
  input  addr_t rd_addr,
  output data_t ram_dat     // registered read data
);

  data_t mem [ram_depth];  // storage array

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (wr_ok)
      mem[wr_addr] <= wr_data;
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // read and write never hit the same word, the pointers keep them apart
  always_ff @(posedge rd_clk)
  begin
    if (ram_rd_en)
      ram_dat <= mem[rd_addr];  // latency 1
  end

endmodule

/* hw/prefetch_ctrl.sv */
// prefetch control
// issues RAM reads ahead of demand so the output stage stays topped up
// tracks held words plus reads in flight, never more than two

module prefetch_ctrl
  import fifo_state_pkg::*;
(
  input  logic rd_clk,
  input  logic rd_rst,
  input  logic empty,        // RAM holds no word
  input  logic pop,          // head word consumed this cycle
  output logic ram_rd_en,    // issue a RAM read
  output logic ram_dat_vld   // RAM data valid, ram_rd_en delayed
);

  pf_state_t state;       // current occupancy
  pf_state_t state_nxt;
  logic      room;        // space for one more word

  ////////////////////////////////////////////////////////////
  // read issue
  ////////////////////////////////////////////////////////////

  assign room      = (state != pf_two) | pop;  // pop frees a slot this edge
  assign ram_rd_en = ~empty & room;

  ////////////////////////////////////////////////////////////
  // occupancy FSM
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;  // hold on both or neither
    if (ram_rd_en & ~pop)
    begin
      case (state)
        pf_none: state_nxt = pf_one;
        pf_one:  state_nxt = pf_two;
        default: state_nxt = state;  // no issue from pf_two without pop
      endcase
    end
    else if (pop & ~ram_rd_en)
    begin
      case (state)
        pf_two:  state_nxt = pf_one;
        pf_one:  state_nxt = pf_none;
        default: state_nxt = state;  // pop implies a held word
      endcase
    end
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      state <= pf_reset_state;
    else
      state <= state_nxt;
  end

  ////////////////////////////////////////////////////////////
  // returning data tag
  ////////////////////////////////////////////////////////////

  // matches the one cycle RAM read latency
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      ram_dat_vld <= 1'b0;
    else
      ram_dat_vld <= ram_rd_en;
  end

endmodule

/* hw/out_reg_fifo.sv */
// output register FIFO
// two entries, head drives the read port directly (first word fall through)
// push and pop in the same cycle are allowed, space is assured by prefetch

module out_reg_fifo
  import fifo_cfg_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst,
  input  logic  in_vld,   // returning RAM word
  input  data_t in_data,
  input  logic  rd_en,    // reader pop request
  output data_t rd_data,  // head word
  output logic  rd_vld,   // head valid
  output logic  pop       // head consumed this cycle
);

  data_t head_dat;
  data_t tail_dat;
  logic  head_vld;
  logic  tail_vld;

  assign pop     = rd_vld & rd_en;  // rd_en alone does nothing
  assign rd_vld  = head_vld;
  assign rd_data = head_dat;

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      head_vld <= 1'b0;
      tail_vld <= 1'b0;
    end
    else
    begin
      case ({in_vld, pop})
        2'b10:   {head_vld, tail_vld} <= {1'b1, head_vld};  // fill head first
        2'b01:   {head_vld, tail_vld} <= {tail_vld, 1'b0};  // tail moves up
        default: {head_vld, tail_vld} <= {head_vld, tail_vld};
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (pop)
    begin
      head_dat <= tail_vld ? tail_dat : in_data;  // next head
      if (in_vld & tail_vld)
        tail_dat <= in_data;
    end
    else if (in_vld)
    begin
      if (head_vld)
        tail_dat <= in_data;
      else
        head_dat <= in_data;
    end
  end

endmodule

/* hw/prefetch_fifo.sv */
// prefetch FIFO top level
// RAM bulk storage with a two-word register stage in front of the reader
// writer sees wr_en/wr_vld, reader sees rd_vld/rd_en, single clock

module prefetch_fifo
  import fifo_cfg_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst,
  input  data_t wr_data,
  input  logic  wr_en,
  output logic  wr_vld,   // not full
  output data_t rd_data,
  input  logic  rd_en,
  output logic  rd_vld    // head word present
);

  logic  wr_ok;        // qualified write
  addr_t wr_addr;
  addr_t rd_addr;
  logic  empty;        // RAM empty
  logic  ram_rd_en;    // prefetch read
  logic  ram_dat_vld;  // read data returning
  data_t ram_dat;
  logic  pop;          // head consumed

  ////////////////////////////////////////////////////////////
  // RAM side
  ////////////////////////////////////////////////////////////

  fifo_ptr_ctrl u_ptr_ctrl (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .wr_en     (wr_en),
    .ram_rd_en (ram_rd_en),
    .wr_vld    (wr_vld),
    .wr_ok     (wr_ok),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .empty     (empty)
  );

  fifo_sdpram u_ram (
    .rd_clk    (rd_clk),
    .wr_ok     (wr_ok),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .ram_rd_en (ram_rd_en),
    .rd_addr   (rd_addr),
    .ram_dat   (ram_dat)
  );

  ////////////////////////////////////////////////////////////
  // reader side
  ////////////////////////////////////////////////////////////

  prefetch_ctrl u_pf_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst      (rd_rst),
    .empty       (empty),
    .pop         (pop),
    .ram_rd_en   (ram_rd_en),
    .ram_dat_vld (ram_dat_vld)
  );

  out_reg_fifo u_out_fifo (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .in_vld  (ram_dat_vld),
    .in_data (ram_dat),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .rd_vld  (rd_vld),
    .pop     (pop)
  );

endmodule

/* tests/tb_clk_gen.sv */
// testbench clock and power-on reset
// 8 ns clock, reset held high for the first 8 rising edges

module tb_clk_gen (
  output logic rd_clk,
  output logic por_rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_ns    = 4;  // half of the 8 ns period
  localparam int rst_cycles = 8;  // edges with reset held

  initial
  begin
    rd_clk = 1'b0;
    forever #(half_ns) rd_clk = ~rd_clk;
  end

  initial
  begin
    por_rst = 1'b1;
    repeat (rst_cycles) @(posedge rd_clk);
    por_rst <= 1'b0;  // release on a rising edge
  end

endmodule

/* tests/tb_prefetch_fifo.sv */
// prefetch FIFO testbench
// directed tests of reset, latency, fill, drain, random streaming and reset
// a negedge monitor keeps the expected word order in a queue

module tb_prefetch_fifo
  import fifo_cfg_pkg::*;
  import fifo_state_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period_ns = 8;
  localparam int stream_cycles = 2000;           // random traffic length
  localparam int fill_limit    = 40;             // bound on writes until full
  localparam int drain_limit   = 80;             // bound on cycles until empty
  localparam int max_words     = ram_depth + 2;  // RAM plus two output entries
  localparam int test_cycles   = 8 + 2 * 24 + fill_limit + 8 + drain_limit + 12
                                 + stream_cycles + drain_limit + 20;
  localparam logic [31:0] rng_seed = 32'hac7d_c6b3;

  logic  rd_clk;
  logic  por_rst;     // power-on reset from the clock module
  logic  rst_mid;     // reset pulse during a test
  logic  rd_rst;
  data_t wr_data;
  logic  wr_en;
  logic  wr_vld;
  data_t rd_data;
  logic  rd_en;
  logic  rd_vld;

  data_t       exp_q[$];        // words accepted but not yet read
  int          err_cnt = 0;
  int          chk_cnt = 0;
  logic [31:0] rng_state;
  logic [1:0]  wr_hist;         // accepted writes on the last two edges
  logic        vld_chk_on;      // rd_vld against queue in streaming only

  ////////////////////////////////////////////////////////////
  // clock, reset and DUT
  ////////////////////////////////////////////////////////////

  tb_clk_gen u_clk_gen (
    .rd_clk  (rd_clk),
    .por_rst (por_rst)
  );

  assign rd_rst = por_rst | rst_mid;

  prefetch_fifo u_dut (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .wr_vld  (wr_vld),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .rd_vld  (rd_vld)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input data_t got, input data_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // monitor samples mid-cycle where inputs and outputs are settled
  // the queue is updated for the rising edge that follows
  always @(negedge rd_clk)
  begin
    if (rd_rst)
    begin
      exp_q.delete();  // stored words are lost on reset
      wr_hist = 2'b00;
    end
    else
    begin
      if (vld_chk_on && wr_hist == 2'b00)
        check_val("rd_vld", data_t'(rd_vld), data_t'(exp_q.size() != 0));
      if (rd_vld && rd_en)
      begin
        if (exp_q.size() == 0)
          note_failure("DUT presented a word that was never written");
        else
          check_val("rd_data", rd_data, exp_q.pop_front());
      end
      if (wr_en && wr_vld)
        exp_q.push_back(wr_data);
      wr_hist = {wr_hist[0], wr_en && wr_vld};
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  // idle values then rd_en pulses against an empty FIFO
  task automatic idle_after_reset();
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));
    check_val("wr_vld", data_t'(wr_vld), data_t'(1));
    repeat (3)
    begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(posedge rd_clk);
      rd_en <= 1'b0;
    end
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));  // pops ignored
    check_val("wr_vld", data_t'(wr_vld), data_t'(1));
    @(posedge rd_clk);
  endtask

  // word stored on edge e1 shows up after e1+2
  task automatic single_word_latency(input data_t word);
    @(posedge rd_clk);
    wr_en   <= 1'b1;
    wr_data <= word;
    @(posedge rd_clk);    // e1 stores the word
    wr_en <= 1'b0;
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));
    @(negedge rd_clk);    // after e2 the RAM read is in flight
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));
    @(negedge rd_clk);    // after e3
    check_val("rd_vld", data_t'(rd_vld), data_t'(1));
    check_val("rd_data", rd_data, word);
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(posedge rd_clk);    // pop
    rd_en <= 1'b0;
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));
  endtask

  // write with no reads until wr_vld falls
  task automatic fill_until_full();
    int accepted;
    int tries;
    int i;
    bit full_seen;
    accepted  = 0;
    full_seen = 1'b0;
    for (tries = 0; tries < fill_limit && !full_seen; tries++)
    begin
      @(posedge rd_clk);
      rd_en   <= 1'b0;
      wr_en   <= 1'b1;
      wr_data <= 32'h5a00_0000 | data_t'(tries);
      @(negedge rd_clk);
      if (wr_vld)
        accepted++;       // taken on the coming edge
      else
        full_seen = 1'b1;
    end
    if (!full_seen)
      note_failure("wr_vld never fell while filling");
    check_val("accepted words", data_t'(accepted), data_t'(max_words));
    for (i = 0; i < 4; i++)
    begin
      @(posedge rd_clk);
      wr_data <= 32'hdead_0000 | data_t'(i);  // all dropped
      @(negedge rd_clk);
      check_val("wr_vld", data_t'(wr_vld), data_t'(0));
    end
    @(posedge rd_clk);
    wr_en <= 1'b0;
    check_val("queue size", data_t'(exp_q.size()), data_t'(max_words));
  endtask

  // pop everything while the monitor checks the order
  task automatic drain_all();
    int popped;
    int waited;
    bit vld_back;
    popped   = 0;
    waited   = 0;
    vld_back = 1'b0;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    while (popped < max_words && waited < drain_limit)
    begin
      @(negedge rd_clk);
      if (rd_vld)
        popped++;
      if (wr_vld)
        vld_back = 1'b1;  // room freed by prefetch
      waited++;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    if (popped < max_words)
      note_failure("drain did not return all stored words in time");
    check_val("popped words", data_t'(popped), data_t'(max_words));
    check_val("wr_vld seen during drain", data_t'(vld_back), data_t'(1));
    repeat (3) @(posedge rd_clk);
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));  // nothing extra left
    check_val("wr_vld", data_t'(wr_vld), data_t'(1));
    @(posedge rd_clk);
    check_val("queue size", data_t'(exp_q.size()), data_t'(0));
  endtask

  // random writes and pops with a write-heavy first half then read-heavy
  task automatic random_streaming();
    logic [31:0] r;
    logic [3:0]  wr_thr;
    logic [3:0]  rd_thr;
    int          cyc;
    int          waited;
    vld_chk_on = 1'b1;
    for (cyc = 0; cyc < stream_cycles; cyc++)
    begin
      @(posedge rd_clk);
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      wr_thr    = (cyc < stream_cycles / 2) ? 4'd12 : 4'd5;
      rd_thr    = (cyc < stream_cycles / 2) ? 4'd5 : 4'd12;
      wr_en    <= (r[3:0] < wr_thr);
      rd_en    <= (r[7:4] < rd_thr);
      rng_state = xorshift32(rng_state);
      wr_data  <= rng_state;
    end
    @(posedge rd_clk);
    wr_en <= 1'b0;
    rd_en <= 1'b1;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit)
    begin
      @(posedge rd_clk);  // queue already holds this edge's pop
      waited++;
    end
    rd_en <= 1'b0;
    if (exp_q.size() != 0)
      note_failure("words left over after the streaming drain");
    repeat (2) @(posedge rd_clk);
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(0));
    vld_chk_on = 1'b0;
  endtask

  // reset with words stored so the FIFO must come back empty and usable
  task automatic reset_mid_stream();
    int i;
    for (i = 0; i < 10; i++)
    begin
      @(posedge rd_clk);
      wr_en   <= 1'b1;
      wr_data <= 32'h3c00_0000 | data_t'(i);
    end
    @(posedge rd_clk);
    wr_en <= 1'b0;
    repeat (4) @(posedge rd_clk);
    check_val("queue size", data_t'(exp_q.size()), data_t'(10));
    @(negedge rd_clk);
    check_val("rd_vld", data_t'(rd_vld), data_t'(1));
    @(posedge rd_clk);
    rst_mid <= 1'b1;
    repeat (3) @(posedge rd_clk);
    rst_mid <= 1'b0;
    @(posedge rd_clk);
    idle_after_reset();
    single_word_latency(32'h0bad_cafe);  // pointers back at zero
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    wr_en      = 1'b0;
    wr_data    = '0;
    rd_en      = 1'b0;
    rst_mid    = 1'b0;
    wr_hist    = 2'b00;
    vld_chk_on = 1'b0;
    rng_state  = rng_seed;
    while (por_rst !== 1'b0)
      @(posedge rd_clk);
    idle_after_reset();
    single_word_latency(32'h1234_5678);
    fill_until_full();
    drain_all();
    random_streaming();
    reset_mid_stream();
    repeat (4) @(posedge rd_clk);
    $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    #((test_cycles + 200) * clk_period_ns);
    $display("timeout: tests still running after %0d ns",
             (test_cycles + 200) * clk_period_ns);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* compile.f */
hw/fifo_cfg_pkg.sv
hw/fifo_state_pkg.sv
hw/fifo_ptr_ctrl.sv
hw/fifo_sdpram.sv
hw/prefetch_ctrl.sv
hw/out_reg_fifo.sv
hw/prefetch_fifo.sv
tests/tb_clk_gen.sv
tests/tb_prefetch_fifo.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the prefetch FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_prefetch_fifo
log=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module "$top" -f compile.f -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1
